// ==== conf_ctrl.sv ====
`timescale 1ns/1ps

module conf_ctrl import versat_conf_pkg::*; (
   input  logic              rst,
   input  logic              clk,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  logic [ADDR_W-1:0] wb_adr,
   input  logic [DATA_W-1:0] wb_dat_i,
   output logic              wb_ack,
   output logic              wb_err,
   conf_wr_if.ctrl           wr
);

   logic req;
   logic wr_en;
   logic is_clear;
   logic mapped;

   // request seen and not answered yet
   assign req = wb_cyc & wb_stb & ~wb_ack & ~wb_err;

   // only writes reach the banks
   assign wr_en = req & wb_we;

   assign is_clear = (wb_adr == ADDR_W'(CONF_CLEAR));

   assign wr.wr_valid = wr_en;
   assign wr.wr_addr = wb_adr;
   assign wr.wr_data = wb_dat_i;
   assign wr.clear = wr_en & is_clear;

   // clear or a field in either bank
   assign mapped = is_clear | wr.mem_hit | wr.fu_hit;

   // answer one cycle after the request and hold it one cycle
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         wb_ack <= 1'b0;
         wb_err <= 1'b0;
      end else begin
         wb_ack <= wr_en & mapped;
         // reads and holes get err
         wb_err <= req & ~(wb_we & mapped);
      end
   end

endmodule

// ==== conf_wr_if.sv ====
`timescale 1ns/1ps

interface conf_wr_if import versat_conf_pkg::*; ();

   // write broadcast from the slave
   logic              wr_valid;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic              clear;

   // address decode results from the banks
   logic mem_hit;
   logic fu_hit;

   modport ctrl (
      output wr_valid,
      output wr_addr,
      output wr_data,
      output clear,
      input  mem_hit,
      input  fu_hit
   );

   modport mem_bank (
      input  wr_valid,
      input  wr_addr,
      input  wr_data,
      input  clear,
      output mem_hit
   );

   modport fu_bank (
      input  wr_valid,
      input  wr_addr,
      input  wr_data,
      input  clear,
      output fu_hit
   );

endinterface

// ==== fu_conf.sv ====
`timescale 1ns/1ps

module fu_conf import versat_conf_pkg::*; (
   input  logic      rst,
   input  logic      clk,
   conf_wr_if.fu_bank wr,
   output alu_conf_t alu_conf [N_ALU],
   output mul_conf_t mul_conf [N_MUL]
);

   logic [ADDR_W-1:0]     alu_rel;
   logic [ADDR_W-1:0]     mul_rel;
   logic [ALU_UNIT_W-1:0] alu_unit;
   logic [MUL_UNIT_W-1:0] mul_unit;
   fu_field_e             alu_field;
   fu_field_e             mul_field;
   logic                  alu_hit;
   logic                  mul_hit;

   assign alu_rel = wr.wr_addr - ADDR_W'(ALU_BASE);
   assign mul_rel = wr.wr_addr - ADDR_W'(MUL_BASE);

   assign alu_unit = alu_rel[FU_FIELD_W +: ALU_UNIT_W];
   assign mul_unit = mul_rel[FU_FIELD_W +: MUL_UNIT_W];
   assign alu_field = fu_field_e'(alu_rel[FU_FIELD_W-1:0]);
   assign mul_field = fu_field_e'(mul_rel[FU_FIELD_W-1:0]);

   // last offset of each unit slot is a hole
   assign alu_hit = (wr.wr_addr >= ADDR_W'(ALU_BASE)) && (wr.wr_addr < ADDR_W'(ALU_END)) &&
                    (alu_field <= FU_FNS);
   assign mul_hit = (wr.wr_addr >= ADDR_W'(MUL_BASE)) && (wr.wr_addr < ADDR_W'(MUL_END)) &&
                    (mul_field <= FU_FNS);

   assign wr.fu_hit = alu_hit | mul_hit;

   // alu selects and function
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_ALU; i++) begin
            alu_conf[i] <= '0;
         end
      end else if (wr.clear) begin
         for (int i = 0; i < N_ALU; i++) begin
            alu_conf[i] <= '0;
         end
      end else if (wr.wr_valid && alu_hit) begin
         case (alu_field)
            FU_SELA: alu_conf[alu_unit].sela <= wr.wr_data[SEL_W-1:0];
            FU_SELB: alu_conf[alu_unit].selb <= wr.wr_data[SEL_W-1:0];
            FU_FNS:  alu_conf[alu_unit].fns <= alu_fns_e'(wr.wr_data[ALU_FNS_W-1:0]);
            default: begin
            end
         endcase
      end
   end

   // multiplier selects and function
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_MUL; i++) begin
            mul_conf[i] <= '0;
         end
      end else if (wr.clear) begin
         for (int i = 0; i < N_MUL; i++) begin
            mul_conf[i] <= '0;
         end
      end else if (wr.wr_valid && mul_hit) begin
         case (mul_field)
            FU_SELA: mul_conf[mul_unit].sela <= wr.wr_data[SEL_W-1:0];
            FU_SELB: mul_conf[mul_unit].selb <= wr.wr_data[SEL_W-1:0];
            FU_FNS:  mul_conf[mul_unit].fns <= wr.wr_data[MUL_FNS_W-1:0];
            default: begin
            end
         endcase
      end
   end

endmodule

// ==== mem_port_conf.sv ====
`timescale 1ns/1ps

module mem_port_conf import versat_conf_pkg::*; (
   input  logic           rst,
   input  logic           clk,
   conf_wr_if.mem_bank    wr,
   output mem_port_conf_t port_conf [N_MEM_PORTS]
);

   logic [ADDR_W-1:0]     rel_addr;
   logic                  in_range;
   logic [MEM_SLOT_W-1:0] slot;
   mem_field_e            field;
   logic                  field_ok;
   logic                  hit;

   // offset from the first port slot
   assign rel_addr = wr.wr_addr - ADDR_W'(MEM_PORT_BASE);

   assign in_range = (wr.wr_addr >= ADDR_W'(MEM_PORT_BASE)) &&
                     (wr.wr_addr < ADDR_W'(MEM_PORT_END));

   // slot index is memory * 2 + port
   assign slot = rel_addr[MEM_FIELD_W +: MEM_SLOT_W];
   assign field = mem_field_e'(rel_addr[MEM_FIELD_W-1:0]);

   // offsets above rvrs are holes
   assign field_ok = (field <= MEM_RVRS);

   assign hit = in_range & field_ok;
   assign wr.mem_hit = hit;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_MEM_PORTS; i++) begin
            port_conf[i] <= '0;
         end
      end else if (wr.clear) begin
         for (int i = 0; i < N_MEM_PORTS; i++) begin
            port_conf[i] <= '0;
         end
      end else if (wr.wr_valid && hit) begin
         // keep only the low bits that fit the field
         case (field)
            MEM_ITER: begin
               port_conf[slot].iter <= wr.wr_data[MEM_ADDR_W-1:0];
            end
            MEM_PER: begin
               port_conf[slot].per <= wr.wr_data[PERIOD_W-1:0];
            end
            MEM_DUTY: begin
               port_conf[slot].duty <= wr.wr_data[PERIOD_W-1:0];
            end
            MEM_SEL: begin
               port_conf[slot].sel <= wr.wr_data[SEL_W-1:0];
            end
            MEM_START: begin
               port_conf[slot].start <= wr.wr_data[MEM_ADDR_W-1:0];
            end
            MEM_SHIFT: begin
               port_conf[slot].shift <= wr.wr_data[MEM_ADDR_W-1:0];
            end
            MEM_INCR: begin
               port_conf[slot].incr <= wr.wr_data[MEM_ADDR_W-1:0];
            end
            MEM_DELAY: begin
               port_conf[slot].delay <= wr.wr_data[PERIOD_W-1:0];
            end
            MEM_RVRS: begin
               port_conf[slot].rvrs <= wr.wr_data[0];
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// ==== versat_conf.f ====
+incdir+.
versat_conf_pkg.sv
conf_wr_if.sv
mem_port_conf.sv
fu_conf.sv
conf_ctrl.sv
versat_conf_top.sv
versat_conf_tb.sv

// ==== versat_conf_pkg.sv ====
package versat_conf_pkg;

   // bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 8;

   // field widths
   localparam int MEM_ADDR_W = 10;
   localparam int PERIOD_W = 5;
   localparam int SEL_W = 5;
   localparam int ALU_FNS_W = 4;
   localparam int MUL_FNS_W = 2;

   // unit counts
   localparam int N_MEM_PORTS = 4;
   localparam int N_ALU = 2;
   localparam int N_MUL = 2;

   // address map
   localparam int CONF_CLEAR = 0;
   localparam int MEM_PORT_BASE = 16;
   localparam int MEM_PORT_STRIDE = 16;
   localparam int ALU_BASE = 80;
   localparam int MUL_BASE = 88;
   localparam int FU_STRIDE = 4;

   localparam int MEM_PORT_END = MEM_PORT_BASE + N_MEM_PORTS * MEM_PORT_STRIDE;
   localparam int ALU_END = ALU_BASE + N_ALU * FU_STRIDE;
   localparam int MUL_END = MUL_BASE + N_MUL * FU_STRIDE;

   // strides are powers of two
   // slot and field bits of a relative address
   localparam int MEM_FIELD_W = $clog2(MEM_PORT_STRIDE);
   localparam int MEM_SLOT_W = $clog2(N_MEM_PORTS);
   localparam int FU_FIELD_W = $clog2(FU_STRIDE);
   localparam int ALU_UNIT_W = $clog2(N_ALU);
   localparam int MUL_UNIT_W = $clog2(N_MUL);

   typedef enum logic [MEM_FIELD_W-1:0] {
      MEM_ITER  = 0,
      MEM_PER   = 1,
      MEM_DUTY  = 2,
      MEM_SEL   = 3,
      MEM_START = 4,
      MEM_SHIFT = 5,
      MEM_INCR  = 6,
      MEM_DELAY = 7,
      MEM_RVRS  = 8
   } mem_field_e;

   typedef enum logic [FU_FIELD_W-1:0] {
      FU_SELA = 0,
      FU_SELB = 1,
      FU_FNS  = 2
   } fu_field_e;

   typedef enum logic [ALU_FNS_W-1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SEXT8,
      ALU_SEXT16,
      ALU_SHRA,
      ALU_SHRL,
      ALU_CMP_SIG,
      ALU_CMP_UNS,
      ALU_CLZ,
      ALU_MAX,
      ALU_MIN,
      ALU_ABS
   } alu_fns_e;

   // one address-generator port, msb first
   typedef struct packed {
      logic [MEM_ADDR_W-1:0] iter;
      logic [PERIOD_W-1:0]   per;
      logic [PERIOD_W-1:0]   duty;
      logic [SEL_W-1:0]      sel;
      logic [MEM_ADDR_W-1:0] start;
      logic [MEM_ADDR_W-1:0] shift;
      logic [MEM_ADDR_W-1:0] incr;
      logic [PERIOD_W-1:0]   delay;
      logic                  rvrs;
   } mem_port_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0] sela;
      logic [SEL_W-1:0] selb;
      alu_fns_e         fns;
   } alu_conf_t;

   typedef struct packed {
      logic [SEL_W-1:0]     sela;
      logic [SEL_W-1:0]     selb;
      logic [MUL_FNS_W-1:0] fns;
   } mul_conf_t;

   localparam int MEM_PORT_BITS = $bits(mem_port_conf_t);
   localparam int ALU_CONF_BITS = $bits(alu_conf_t);
   localparam int MUL_CONF_BITS = $bits(mul_conf_t);

   localparam int MEM_CONF_BITS = N_MEM_PORTS * MEM_PORT_BITS;
   localparam int FU_CONF_BITS = N_ALU * ALU_CONF_BITS + N_MUL * MUL_CONF_BITS;
   localparam int CONF_BITS = MEM_CONF_BITS + FU_CONF_BITS;

endpackage

// ==== versat_conf_tb_tasks.svh ====
// one bus cycle that returns whether ack came and conf_out in the answer cycle
task automatic wb_write(input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input string name,
                        output logic got_ack, output logic [CONF_BITS-1:0] conf_seen);
   int   waited;
   logic answered;
   wb_cyc = 1'b1;
   wb_stb = 1'b1;
   wb_we = we;
   wb_adr = addr;
   wb_dat_i = data;
   waited = 0;
   answered = 1'b0;
   while (!answered && waited < TIMEOUT_CYCLES) begin
      @(negedge rst);
      waited++;
      answered = wb_ack | wb_err;
   end
   got_ack = wb_ack;
   conf_seen = conf_out;
   if (!answered) begin
      $display("%s: no ack or err within %0d cycles at addr %0d", name, TIMEOUT_CYCLES, addr);
      errors++;
      timed_out = 1'b1;
   end else begin
      if (waited != 1) begin
         $display("%s: answer came %0d cycles after the request, not 1", name, waited);
         errors++;
      end
      if (wb_ack && wb_err) begin
         $display("%s: ack and err were high together", name);
         errors++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      @(negedge rst);
      if (wb_ack || wb_err) begin
         $display("%s: answer stayed high for more than one cycle", name);
         errors++;
      end
   end
endtask

task automatic after_reset();
   if (conf_out !== '0) begin
      $display("MISMATCH after_reset: expected %h, actual %h", CONF_BITS'(0), conf_out);
      errors++;
   end
   if (wb_ack !== 1'b0 || wb_err !== 1'b0) begin
      $display("MISMATCH after_reset: expected ack/err 00, actual %b%b", wb_ack, wb_err);
      errors++;
   end
endtask

task automatic mem_port_fields();
   logic [DATA_W-1:0]    data;
   logic [ADDR_W-1:0]    addr;
   logic                 got_ack;
   logic [CONF_BITS-1:0] seen;
   for (int p = 0; p < N_MEM_PORTS; p++) begin
      for (int f = 0; f <= int'(MEM_RVRS); f++) begin
         data = $random(seed);
         addr = ADDR_W'(MEM_PORT_BASE + p * MEM_PORT_STRIDE + f);
         wb_write(1'b1, addr, data, "mem_port_fields", got_ack, seen);
         if (timed_out) begin
            return;
         end
         set_mem_ref(p, f, data);
         if (got_ack !== 1'b1) begin
            $display("MISMATCH mem_port_fields: expected ack 1, actual %b", got_ack);
            errors++;
         end
         if (seen !== ref_conf()) begin
            $display("MISMATCH mem_port_fields: expected %h, actual %h", ref_conf(), seen);
            errors++;
         end
      end
   end
endtask

task automatic fu_fields();
   logic [DATA_W-1:0]    data;
   logic [ADDR_W-1:0]    addr;
   logic                 got_ack;
   logic [CONF_BITS-1:0] seen;
   // k = 0 for the alus, 1 for the multipliers
   for (int k = 0; k < 2; k++) begin
      for (int u = 0; u < ((k != 0) ? N_MUL : N_ALU); u++) begin
         for (int f = 0; f <= int'(FU_FNS); f++) begin
            data = $random(seed);
            addr = ADDR_W'(((k != 0) ? MUL_BASE : ALU_BASE) + u * FU_STRIDE + f);
            wb_write(1'b1, addr, data, "fu_fields", got_ack, seen);
            if (timed_out) begin
               return;
            end
            set_fu_ref(k, u, f, data);
            if (got_ack !== 1'b1) begin
               $display("MISMATCH fu_fields: expected ack 1, actual %b", got_ack);
               errors++;
            end
            if (seen !== ref_conf()) begin
               $display("MISMATCH fu_fields: expected %h, actual %h", ref_conf(), seen);
               errors++;
            end
         end
      end
   end
endtask

task automatic unmapped_access();
   logic [ADDR_W-1:0]    holes [5];
   logic [DATA_W-1:0]    data;
   logic                 got_ack;
   logic [CONF_BITS-1:0] seen;
   holes = '{ADDR_W'(MEM_PORT_BASE + 9), ADDR_W'(MEM_PORT_BASE + 3 * MEM_PORT_STRIDE + 15),
             ADDR_W'(ALU_BASE + 3), ADDR_W'(MUL_BASE + FU_STRIDE + 3), ADDR_W'(200)};
   for (int i = 0; i < 6; i++) begin
      data = $random(seed);
      // last pass is a read of a mapped field
      if (i < 5) begin
         wb_write(1'b1, holes[i], data, "unmapped_access", got_ack, seen);
      end else begin
         wb_write(1'b0, ADDR_W'(MEM_PORT_BASE), data, "unmapped_access", got_ack, seen);
      end
      if (timed_out) begin
         return;
      end
      if (got_ack !== 1'b0) begin
         $display("MISMATCH unmapped_access: expected ack 0, actual %b", got_ack);
         errors++;
      end
      if (seen !== ref_conf()) begin
         $display("MISMATCH unmapped_access: expected %h, actual %h", ref_conf(), seen);
         errors++;
      end
   end
endtask

task automatic clear_command();
   logic [DATA_W-1:0]    data;
   logic                 got_ack;
   logic [CONF_BITS-1:0] seen;
   data = $random(seed);
   wb_write(1'b1, ADDR_W'(CONF_CLEAR), data, "clear_command", got_ack, seen);
   if (timed_out) begin
      return;
   end
   clear_ref();
   if (got_ack !== 1'b1) begin
      $display("MISMATCH clear_command: expected ack 1, actual %b", got_ack);
      errors++;
   end
   if (seen !== ref_conf()) begin
      $display("MISMATCH clear_command: expected %h, actual %h", ref_conf(), seen);
      errors++;
   end
endtask

// ==== versat_conf_tb.sv ====
`timescale 1ns/1ps

module versat_conf_tb import versat_conf_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 20;

   // rst is the clock and clk the reset
   logic                 rst;
   logic                 clk;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   logic [ADDR_W-1:0]    wb_adr;
   logic [DATA_W-1:0]    wb_dat_i;
   logic                 wb_ack;
   logic                 wb_err;
   logic [CONF_BITS-1:0] conf_out;

   integer seed;
   int     errors;
   bit     timed_out;

   // reference model of the stored configuration
   mem_port_conf_t ref_mem [N_MEM_PORTS];
   alu_conf_t      ref_alu [N_ALU];
   mul_conf_t      ref_mul [N_MUL];

   versat_conf_top versat_conf_top_i (
      .rst      (rst),
      .clk      (clk),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .wb_err   (wb_err),
      .conf_out (conf_out)
   );

   always #2 rst = ~rst;

   // memory ports first, then alus, then multipliers
   function automatic logic [CONF_BITS-1:0] ref_conf();
      logic [CONF_BITS-1:0] v;
      v = '0;
      for (int i = 0; i < N_MEM_PORTS; i++) begin
         v = (v << MEM_PORT_BITS) | CONF_BITS'(ref_mem[i]);
      end
      for (int i = 0; i < N_ALU; i++) begin
         v = (v << ALU_CONF_BITS) | CONF_BITS'(ref_alu[i]);
      end
      for (int i = 0; i < N_MUL; i++) begin
         v = (v << MUL_CONF_BITS) | CONF_BITS'(ref_mul[i]);
      end
      return v;
   endfunction

   task automatic clear_ref();
      for (int i = 0; i < N_MEM_PORTS; i++) begin
         ref_mem[i] = '0;
      end
      for (int i = 0; i < N_ALU; i++) begin
         ref_alu[i] = '0;
      end
      for (int i = 0; i < N_MUL; i++) begin
         ref_mul[i] = '0;
      end
   endtask

   // each field keeps only the low bits of the bus data
   task automatic set_mem_ref(input int p, input int f, input logic [DATA_W-1:0] data);
      case (f)
         MEM_ITER:  ref_mem[p].iter = data[MEM_ADDR_W-1:0];
         MEM_PER:   ref_mem[p].per = data[PERIOD_W-1:0];
         MEM_DUTY:  ref_mem[p].duty = data[PERIOD_W-1:0];
         MEM_SEL:   ref_mem[p].sel = data[SEL_W-1:0];
         MEM_START: ref_mem[p].start = data[MEM_ADDR_W-1:0];
         MEM_SHIFT: ref_mem[p].shift = data[MEM_ADDR_W-1:0];
         MEM_INCR:  ref_mem[p].incr = data[MEM_ADDR_W-1:0];
         MEM_DELAY: ref_mem[p].delay = data[PERIOD_W-1:0];
         MEM_RVRS:  ref_mem[p].rvrs = data[0];
         default: begin
         end
      endcase
   endtask

   task automatic set_fu_ref(input int is_mul, input int u, input int f,
                             input logic [DATA_W-1:0] data);
      if (is_mul != 0) begin
         case (f)
            FU_SELA: ref_mul[u].sela = data[SEL_W-1:0];
            FU_SELB: ref_mul[u].selb = data[SEL_W-1:0];
            FU_FNS:  ref_mul[u].fns = data[MUL_FNS_W-1:0];
            default: begin
            end
         endcase
      end else begin
         case (f)
            FU_SELA: ref_alu[u].sela = data[SEL_W-1:0];
            FU_SELB: ref_alu[u].selb = data[SEL_W-1:0];
            FU_FNS:  ref_alu[u].fns = alu_fns_e'(data[ALU_FNS_W-1:0]);
            default: begin
            end
         endcase
      end
   endtask

   task automatic end_run();
      $display("run complete, error count: %0d", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   `include "versat_conf_tb_tasks.svh"

   initial begin
      seed = 32'h63b2_00c2;
      errors = 0;
      timed_out = 1'b0;
      rst = 1'b0;
      clk = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_i = '0;
      clear_ref();
      repeat (10) @(negedge rst);
      clk = 1'b0;
      after_reset();
      mem_port_fields();
      // a hung bus ends the sequence early
      if (!timed_out) begin
         fu_fields();
      end
      if (!timed_out) begin
         unmapped_access();
      end
      if (!timed_out) begin
         clear_command();
      end
      end_run();
   end

endmodule

// ==== versat_conf_top.sv ====
`timescale 1ns/1ps

module versat_conf_top import versat_conf_pkg::*; (
   input  logic                 rst,
   input  logic                 clk,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [ADDR_W-1:0]    wb_adr,
   input  logic [DATA_W-1:0]    wb_dat_i,
   output logic                 wb_ack,
   output logic                 wb_err,
   output logic [CONF_BITS-1:0] conf_out
);

   mem_port_conf_t port_conf [N_MEM_PORTS];
   alu_conf_t      alu_conf [N_ALU];
   mul_conf_t      mul_conf [N_MUL];

   conf_wr_if wr_bus ();

   conf_ctrl conf_ctrl_i (
      .rst      (rst),
      .clk      (clk),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .wb_err   (wb_err),
      .wr       (wr_bus.ctrl)
   );

   mem_port_conf mem_port_conf_i (
      .rst       (rst),
      .clk       (clk),
      .wr        (wr_bus.mem_bank),
      .port_conf (port_conf)
   );

   fu_conf fu_conf_i (
      .rst      (rst),
      .clk      (clk),
      .wr       (wr_bus.fu_bank),
      .alu_conf (alu_conf),
      .mul_conf (mul_conf)
   );

   // memory ports on top, port 0 first
   for (genvar i = 0; i < N_MEM_PORTS; i++) begin : g_mem_pack
      assign conf_out[CONF_BITS-1-i*MEM_PORT_BITS -: MEM_PORT_BITS] = port_conf[i];
   end

   // then the alus
   for (genvar i = 0; i < N_ALU; i++) begin : g_alu_pack
      assign conf_out[FU_CONF_BITS-1-i*ALU_CONF_BITS -: ALU_CONF_BITS] = alu_conf[i];
   end

   // multipliers in the low bits
   for (genvar i = 0; i < N_MUL; i++) begin : g_mul_pack
      assign conf_out[N_MUL*MUL_CONF_BITS-1-i*MUL_CONF_BITS -: MUL_CONF_BITS] = mul_conf[i];
   end

endmodule
